// File: files.f
+incdir+include
design/isa_pkg.sv
design/scoreboard_pkg.sv
design/register_file.sv
design/scoreboard.sv
design/issue_stage.sv
design/issue_unit.sv
tests/issue_checks.sv
tests/tb_issue_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the issue unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_issue_unit -f files.f -o sim_issue_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_issue_unit > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
exit 0

// File: tests/tb_issue_unit.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module tb_issue_unit;

    import isa_pkg::*;

    localparam int MAX_CYCLES = 400;
    localparam opcode_t OP_ADDI = 6'b001000;
    localparam opcode_t OPS [5] = '{`OP_LW, `OP_SW, `OP_SPECIAL, `OP_SPECIAL, 6'b001000};
    localparam funct_t FUNCTS [5] = '{6'd0, 6'd0, `FUNCT_MULT, 6'b100000, 6'd0};

    logic        clock;
    logic        reset;
    decoded_t    instr;
    reg_addr_t   id_addr_a;
    logic        id_check_a;
    reg_addr_t   id_addr_b;
    logic        id_check_b;
    logic        wb_en;
    reg_addr_t   wb_addr;
    word_t       wb_data;
    exec_t       exec;
    logic        exec_valid;
    logic        stall;
    logic        id_stall;
    int unsigned lcg_state = 25;
    int          cycle_count = 0;

    issue_unit issue_unit_i (.*);

    bind issue_unit issue_checks checks_i (
        .clock      (clock),
        .reset      (reset),
        .instr      (instr),
        .id_addr_a  (id_addr_a),
        .id_check_a (id_check_a),
        .id_addr_b  (id_addr_b),
        .id_check_b (id_check_b),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .exec       (exec),
        .exec_valid (exec_valid),
        .stall      (stall),
        .id_stall   (id_stall)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic decoded_t make_instr(input opcode_t op, input funct_t funct,
                                            input reg_addr_t dest, input reg_addr_t src_a,
                                            input reg_addr_t src_b, input logic uses_b,
                                            input logic writereg);
        decoded_t    d;
        logic [31:0] r;
        r = next_random();
        d = '0;
        d.aluop       = r[18:16];
        d.selalushift = r[19];
        d.selimregb   = r[20];
        d.unsig       = r[21];
        d.shiftop     = r[23:22];
        d.readmem     = (op == `OP_LW);
        d.writemem    = (op == `OP_SW);
        d.imedext     = next_random();
        d.selwsource  = r[24];
        d.writeov     = r[25];
        d.regdest     = dest;
        d.writereg    = writereg;
        d.addr_a      = src_a;
        d.addr_b      = src_b;
        d.uses_b      = uses_b;
        d.op          = op;
        d.funct       = funct;
        return d;
    endfunction

    task finish_with_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task next_cycle();
        @(posedge clock);
        #1;
    endtask

    // Decode holds the instruction until the stall drops
    task automatic issue_instr(input decoded_t d, input reg_addr_t ahead_a, input reg_addr_t ahead_b);
        instr      = d;
        id_addr_a  = ahead_a;
        id_check_a = 1'b1;
        id_addr_b  = ahead_b;
        id_check_b = next_random() > 32'h8000_0000;
        @(negedge clock);
        while (stall) begin
            @(negedge clock);
        end
        next_cycle();
    endtask

    task automatic write_back(input reg_addr_t addr, input word_t data);
        wb_en   = 1'b1;
        wb_addr = addr;
        wb_data = data;
        next_cycle();
        wb_en = 1'b0;
    endtask

    // Producer then a reader of its destination on source a or b
    task automatic run_dependency(input opcode_t op, input funct_t funct, input logic on_b,
                                  input logic uses_b);
        logic [31:0] r;
        reg_addr_t   rd;
        r  = next_random();
        rd = 5'd8 + {2'b00, r[18:16]};
        issue_instr(make_instr(op, funct, rd, 5'd1, 5'd2, 1'b1, 1'b1), rd, 5'd0);
        if (on_b) begin
            issue_instr(make_instr(OP_ADDI, 6'd0, 5'd0, 5'd0, rd, uses_b, 1'b0), 5'd0, rd);
        end else begin
            issue_instr(make_instr(OP_ADDI, 6'd0, 5'd0, rd, 5'd0, uses_b, 1'b0), rd, 5'd0);
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            finish_with_failure("Timeout: the run went past its cycle limit");
        end
    end

    always @(negedge clock) begin
        if (issue_unit_i.checks_i.failed) begin
            finish_with_failure("A check in the checker module did not hold");
        end
    end

    initial begin
        logic [31:0] r;
        int          k;
        instr      = '0;
        id_addr_a  = '0;
        id_check_a = 1'b0;
        id_addr_b  = '0;
        id_check_b = 1'b0;
        wb_en      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        reset      = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1;

        // Fill every register, r0 included
        for (int i = 0; i < `REG_COUNT; i++) begin
            write_back(reg_addr_t'(i), next_random());
        end

        // Unit classes and operand reads without destinations
        issue_instr(make_instr(`OP_LW, 6'd0, 5'd0, 5'd1, 5'd2, 1'b0, 1'b0), 5'd1, 5'd2);
        issue_instr(make_instr(`OP_SW, 6'd0, 5'd0, 5'd3, 5'd4, 1'b1, 1'b0), 5'd3, 5'd4);
        issue_instr(make_instr(`OP_SPECIAL, `FUNCT_MULT, 5'd0, 5'd5, 5'd6, 1'b1, 1'b0), 5'd5, 5'd6);
        issue_instr(make_instr(`OP_SPECIAL, 6'b100000, 5'd0, 5'd7, 5'd0, 1'b1, 1'b0), 5'd7, 5'd0);
        issue_instr(make_instr(OP_ADDI, 6'd0, 5'd0, 5'd0, 5'd9, 1'b1, 1'b0), 5'd0, 5'd9);
        issue_instr(make_instr(6'b001101, 6'd0, 5'd0, 5'd31, 5'd30, 1'b1, 1'b0), 5'd31, 5'd30);

        // RAW hazards behind each unit
        run_dependency(OP_ADDI, 6'd0, 1'b0, 1'b0);
        run_dependency(`OP_LW, 6'd0, 1'b0, 1'b1);
        run_dependency(`OP_SPECIAL, `FUNCT_MULT, 1'b0, 1'b1);
        run_dependency(`OP_LW, 6'd0, 1'b1, 1'b1);
        run_dependency(`OP_SPECIAL, `FUNCT_MULT, 1'b1, 1'b0);

        // Destinations that must never be marked
        issue_instr(make_instr(OP_ADDI, 6'd0, 5'd0, 5'd3, 5'd4, 1'b1, 1'b1), 5'd0, 5'd0);
        issue_instr(make_instr(OP_ADDI, 6'd0, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0), 5'd0, 5'd0);
        issue_instr(make_instr(`OP_LW, 6'd0, 5'd20, 5'd5, 5'd6, 1'b0, 1'b0), 5'd20, 5'd0);
        issue_instr(make_instr(OP_ADDI, 6'd0, 5'd0, 5'd20, 5'd20, 1'b1, 1'b0), 5'd20, 5'd20);

        // Random mix on a few registers so that hazards come often
        for (int n = 0; n < 40; n++) begin
            r       = next_random();
            k       = int'(r[26:24]) % 5;
            wb_en   = r[0];
            wb_addr = {2'b00, r[5:3]};
            wb_data = next_random();
            issue_instr(make_instr(OPS[k], FUNCTS[k], {2'b00, r[10:8]}, {2'b00, r[13:11]},
                                   {2'b00, r[16:14]}, r[1], r[2]),
                        {2'b00, r[19:17]}, {2'b00, r[22:20]});
        end
        wb_en = 1'b0;
        repeat (3) next_cycle();

        if (issue_unit_i.checks_i.failed) begin
            finish_with_failure("A check in the checker module did not hold");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: tests/issue_checks.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_checks (
    input logic               clock,
    input logic               reset,
    input isa_pkg::decoded_t  instr,
    input isa_pkg::reg_addr_t id_addr_a,
    input logic               id_check_a,
    input isa_pkg::reg_addr_t id_addr_b,
    input logic               id_check_b,
    input logic               wb_en,
    input isa_pkg::reg_addr_t wb_addr,
    input isa_pkg::word_t     wb_data,
    input isa_pkg::exec_t     exec,
    input logic               exec_valid,
    input logic               stall,
    input logic               id_stall
);

    import isa_pkg::*;
    import scoreboard_pkg::*;

    // Controls that pass from decode to execution unchanged
    typedef struct packed {
        logic [2:0] aluop;
        logic       selalushift;
        logic       selimregb;
        logic       unsig;
        logic [1:0] shiftop;
        logic       readmem;
        logic       writemem;
        word_t      imedext;
        logic       selwsource;
        reg_addr_t  regdest;
        logic       writereg;
        logic       writeov;
    } controls_t;

    // Shadow copies of the register file and of the pending countdowns
    word_t     shadow_regs [`REG_COUNT];
    row_t      shadow_rows [`REG_COUNT];
    unit_e     decoded_unit;
    logic      exp_stall;
    logic      exp_id_stall;
    logic      exp_mark;
    logic      exp_valid;
    unit_e     exp_unit;
    word_t     exp_rega;
    word_t     exp_regb;
    controls_t exp_controls;
    logic      seen_edge = 1'b0;
    logic      failed = 1'b0;

    function automatic unit_e unit_for(input opcode_t op, input funct_t funct);
        if (op == `OP_LW || op == `OP_SW) begin
            return unit_mem;
        end
        if (op == `OP_SPECIAL && funct == `FUNCT_MULT) begin
            return unit_mul;
        end
        return unit_alu;
    endfunction

    function automatic row_t latency_of(input unit_e unit);
        case (unit)
            unit_mem: return row_t'(`LAT_MEM);
            unit_mul: return row_t'(`LAT_MUL);
            default:  return row_t'(`LAT_ALU);
        endcase
    endfunction

    // r0 always reads zero whatever was written to it
    function automatic word_t shadow_read(input reg_addr_t addr);
        return (addr == '0) ? '0 : shadow_regs[addr];
    endfunction

    function automatic controls_t controls_from_instr(input decoded_t d);
        return {d.aluop, d.selalushift, d.selimregb, d.unsig, d.shiftop, d.readmem,
                d.writemem, d.imedext, d.selwsource, d.regdest, d.writereg, d.writeov};
    endfunction

    function automatic controls_t controls_from_exec(input exec_t e);
        return {e.aluop, e.selalushift, e.selimregb, e.unsig, e.shiftop, e.readmem,
                e.writemem, e.imedext, e.selwsource, e.regdest, e.writereg, e.writeov};
    endfunction

    assign decoded_unit = unit_for(instr.op, instr.funct);
    assign exp_stall    = (shadow_rows[instr.addr_a] != '0)
                       || (instr.uses_b && shadow_rows[instr.addr_b] != '0);
    assign exp_id_stall = (id_check_a && shadow_rows[id_addr_a] != '0)
                       || (id_check_b && shadow_rows[id_addr_b] != '0);
    assign exp_mark     = !exp_stall && instr.writereg && instr.regdest != '0;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow_regs[i] <= '0;
                shadow_rows[i] <= '0;
            end
            exp_valid    <= 1'b0;
            exp_unit     <= unit_none;
            exp_rega     <= '0;
            exp_regb     <= '0;
            exp_controls <= '0;
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (exp_mark && instr.regdest == reg_addr_t'(i)) begin
                    shadow_rows[i] <= latency_of(decoded_unit);
                end else if (shadow_rows[i] != '0) begin
                    shadow_rows[i] <= shadow_rows[i] - row_t'(1);
                end
            end
            if (wb_en) begin
                shadow_regs[wb_addr] <= wb_data;
            end
            exp_valid    <= !exp_stall;
            exp_unit     <= exp_stall ? unit_none : decoded_unit;
            exp_rega     <= shadow_read(instr.addr_a);
            exp_regb     <= shadow_read(instr.addr_b);
            exp_controls <= controls_from_instr(instr);
        end
    end

    always @(posedge clock) begin
        seen_edge <= 1'b1;
    end

    a_reset_state: assert property (@(posedge clock)
        (!reset && seen_edge) |-> (!exec_valid && exec.unit == unit_none && !stall && !id_stall))
        else begin
            failed = 1'b1;
            $error("outputs not at their reset values while reset is held");
        end

    a_stall: assert property (@(posedge clock) disable iff (!reset) stall == exp_stall)
        else begin
            failed = 1'b1;
            $error("FAILED stall: got 0x%h expected 0x%h",
                   $sampled(stall), $sampled(exp_stall));
        end

    a_id_stall: assert property (@(posedge clock) disable iff (!reset) id_stall == exp_id_stall)
        else begin
            failed = 1'b1;
            $error("FAILED id_stall: got 0x%h expected 0x%h",
                   $sampled(id_stall), $sampled(exp_id_stall));
        end

    a_exec_valid: assert property (@(posedge clock) disable iff (!reset) exec_valid == exp_valid)
        else begin
            failed = 1'b1;
            $error("FAILED exec_valid: got 0x%h expected 0x%h",
                   $sampled(exec_valid), $sampled(exp_valid));
        end

    a_exec_unit: assert property (@(posedge clock) disable iff (!reset) exec.unit == exp_unit)
        else begin
            failed = 1'b1;
            $error("FAILED exec.unit: got 0x%h expected 0x%h",
                   $sampled(exec.unit), $sampled(exp_unit));
        end

    a_rega: assert property (@(posedge clock) disable iff (!reset)
        exp_valid |-> exec.rega == exp_rega)
        else begin
            failed = 1'b1;
            $error("FAILED exec.rega: got 0x%h expected 0x%h",
                   $sampled(exec.rega), $sampled(exp_rega));
        end

    a_regb: assert property (@(posedge clock) disable iff (!reset)
        exp_valid |-> exec.regb == exp_regb)
        else begin
            failed = 1'b1;
            $error("FAILED exec.regb: got 0x%h expected 0x%h",
                   $sampled(exec.regb), $sampled(exp_regb));
        end

    // Shift amount comes from the low bits of operand a
    a_shiftamt: assert property (@(posedge clock) disable iff (!reset)
        exp_valid |-> exec.shiftamt == exp_rega[4:0])
        else begin
            failed = 1'b1;
            $error("FAILED exec.shiftamt: got 0x%h expected 0x%h",
                   $sampled(exec.shiftamt), $sampled(exp_rega[4:0]));
        end

    a_controls: assert property (@(posedge clock) disable iff (!reset)
        exp_valid |-> controls_from_exec(exec) == exp_controls)
        else begin
            failed = 1'b1;
            $error("FAILED exec controls: got 0x%h expected 0x%h",
                   controls_from_exec($sampled(exec)), $sampled(exp_controls));
        end

endmodule

// File: design/issue_unit.sv
`timescale 1ns/1ps

module issue_unit (
    input  logic               clock,
    input  logic               reset,
    input  isa_pkg::decoded_t  instr,
    input  isa_pkg::reg_addr_t id_addr_a,
    input  logic               id_check_a,
    input  isa_pkg::reg_addr_t id_addr_b,
    input  logic               id_check_b,
    input  logic               wb_en,
    input  isa_pkg::reg_addr_t wb_addr,
    input  isa_pkg::word_t     wb_data,
    output isa_pkg::exec_t     exec,
    output logic               exec_valid,
    output logic               stall,
    output logic               id_stall
);

    import isa_pkg::*;
    import scoreboard_pkg::*;

    reg_addr_t  read_addr_a;
    reg_addr_t  read_addr_b;
    word_t      read_data_a;
    word_t      read_data_b;
    sb_lookup_t lookup_a;
    sb_lookup_t lookup_b;
    sb_lookup_t lookahead_a;
    sb_lookup_t lookahead_b;
    logic       mark_en;
    reg_addr_t  mark_addr;
    unit_e      mark_unit;
    row_t       mark_row;

    // Architectural registers, written back by the testbench
    register_file register_file_i (
        .clock       (clock),
        .reset       (reset),
        .read_addr_a (read_addr_a),
        .read_addr_b (read_addr_b),
        .write_en    (wb_en),
        .write_addr  (wb_addr),
        .write_data  (wb_data),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b)
    );

    scoreboard scoreboard_i (
        .clock            (clock),
        .reset            (reset),
        .lookup_addr_a    (instr.addr_a),
        .lookup_addr_b    (instr.addr_b),
        .lookahead_addr_a (id_addr_a),
        .lookahead_addr_b (id_addr_b),
        .mark_en          (mark_en),
        .mark_addr        (mark_addr),
        .mark_unit        (mark_unit),
        .mark_row         (mark_row),
        .lookup_a         (lookup_a),
        .lookup_b         (lookup_b),
        .lookahead_a      (lookahead_a),
        .lookahead_b      (lookahead_b)
    );

    issue_stage issue_stage_i (
        .clock       (clock),
        .reset       (reset),
        .instr       (instr),
        .id_addr_a   (id_addr_a),
        .id_check_a  (id_check_a),
        .id_addr_b   (id_addr_b),
        .id_check_b  (id_check_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .lookup_a    (lookup_a),
        .lookup_b    (lookup_b),
        .lookahead_a (lookahead_a),
        .lookahead_b (lookahead_b),
        .read_addr_a (read_addr_a),
        .read_addr_b (read_addr_b),
        .mark_en     (mark_en),
        .mark_addr   (mark_addr),
        .mark_unit   (mark_unit),
        .mark_row    (mark_row),
        .stall       (stall),
        .id_stall    (id_stall),
        .exec        (exec),
        .exec_valid  (exec_valid)
    );

endmodule

// File: design/issue_stage.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage (
    input  logic                       clock,
    input  logic                       reset,
    input  isa_pkg::decoded_t          instr,
    input  isa_pkg::reg_addr_t         id_addr_a,
    input  logic                       id_check_a,
    input  isa_pkg::reg_addr_t         id_addr_b,
    input  logic                       id_check_b,
    input  isa_pkg::word_t             read_data_a,
    input  isa_pkg::word_t             read_data_b,
    input  scoreboard_pkg::sb_lookup_t lookup_a,
    input  scoreboard_pkg::sb_lookup_t lookup_b,
    input  scoreboard_pkg::sb_lookup_t lookahead_a,
    input  scoreboard_pkg::sb_lookup_t lookahead_b,
    output isa_pkg::reg_addr_t         read_addr_a,
    output isa_pkg::reg_addr_t         read_addr_b,
    output logic                       mark_en,
    output isa_pkg::reg_addr_t         mark_addr,
    output isa_pkg::unit_e             mark_unit,
    output scoreboard_pkg::row_t       mark_row,
    output logic                       stall,
    output logic                       id_stall,
    output isa_pkg::exec_t             exec,
    output logic                       exec_valid
);

    import isa_pkg::*;
    import scoreboard_pkg::*;

    unit_e unit;
    row_t  latency;

    // Register file is addressed straight from the decoded sources
    assign read_addr_a = instr.addr_a;
    assign read_addr_b = instr.addr_b;

    // Functional unit from opcode and funct
    always_comb begin
        if (instr.op == `OP_LW || instr.op == `OP_SW) begin
            unit = unit_mem;
        end else if (instr.op == `OP_SPECIAL && instr.funct == `FUNCT_MULT) begin
            unit = unit_mul;
        end else begin
            unit = unit_alu;
        end
    end

    always_comb begin
        case (unit)
            unit_mem: latency = row_t'(`LAT_MEM);
            unit_mul: latency = row_t'(`LAT_MUL);
            default:  latency = row_t'(`LAT_ALU);
        endcase
    end

    // RAW hazards, source b counts only when the instruction reads it
    assign stall    = lookup_a.pending || (instr.uses_b && lookup_b.pending);
    assign id_stall = (id_check_a && lookahead_a.pending)
                   || (id_check_b && lookahead_b.pending);

    // Reserve the destination as the instruction leaves for execution
    assign mark_en   = !stall && instr.writereg && instr.regdest != '0;
    assign mark_addr = instr.regdest;
    assign mark_unit = unit;
    assign mark_row  = latency;

    // Execution-bound register, a stall sends a bubble
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            exec       <= '0;
            exec.unit  <= unit_none;
            exec_valid <= 1'b0;
        end else if (stall) begin
            exec.unit  <= unit_none;
            exec_valid <= 1'b0;
        end else begin
            exec.aluop       <= instr.aluop;
            exec.selalushift <= instr.selalushift;
            exec.selimregb   <= instr.selimregb;
            exec.unsig       <= instr.unsig;
            exec.shiftop     <= instr.shiftop;
            exec.shiftamt    <= read_data_a[4:0];
            exec.readmem     <= instr.readmem;
            exec.writemem    <= instr.writemem;
            exec.imedext     <= instr.imedext;
            exec.selwsource  <= instr.selwsource;
            exec.regdest     <= instr.regdest;
            exec.writereg    <= instr.writereg;
            exec.writeov     <= instr.writeov;
            exec.rega        <= read_data_a;
            exec.regb        <= read_data_b;
            exec.unit        <= unit;
            exec_valid       <= 1'b1;
        end
    end

    // Bubbles never carry a valid qualifier
    a_bubble_not_valid: assert property (
        @(posedge clock) disable iff (!reset)
        (exec.unit == unit_none) |-> !exec_valid
    ) else $error("issue_stage: exec_valid set on a bubble");

endmodule

// File: design/scoreboard.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module scoreboard (
    input  logic                      clock,
    input  logic                      reset,
    input  isa_pkg::reg_addr_t        lookup_addr_a,
    input  isa_pkg::reg_addr_t        lookup_addr_b,
    input  isa_pkg::reg_addr_t        lookahead_addr_a,
    input  isa_pkg::reg_addr_t        lookahead_addr_b,
    input  logic                      mark_en,
    input  isa_pkg::reg_addr_t        mark_addr,
    input  isa_pkg::unit_e            mark_unit,
    input  scoreboard_pkg::row_t      mark_row,
    output scoreboard_pkg::sb_lookup_t lookup_a,
    output scoreboard_pkg::sb_lookup_t lookup_b,
    output scoreboard_pkg::sb_lookup_t lookahead_a,
    output scoreboard_pkg::sb_lookup_t lookahead_b
);

    import isa_pkg::*;
    import scoreboard_pkg::*;

    // Countdown and producing unit per architectural register
    row_t  rows  [`REG_COUNT];
    unit_e units [`REG_COUNT];

    function automatic sb_lookup_t read_entry(input reg_addr_t addr);
        sb_lookup_t result;
        result.pending = (rows[addr] != '0);
        result.unit    = units[addr];
        result.row     = rows[addr];
        return result;
    endfunction

    // A fresh mark wins over the running countdown of the same register
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                rows[i]  <= '0;
                units[i] <= unit_none;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (mark_en && mark_addr == reg_addr_t'(i)) begin
                    rows[i]  <= mark_row;
                    units[i] <= mark_unit;
                end else if (rows[i] != '0) begin
                    rows[i] <= rows[i] - row_t'(1);
                end
            end
        end
    end

    // Issue side and decode lookahead see the same table
    always_comb begin
        lookup_a    = read_entry(lookup_addr_a);
        lookup_b    = read_entry(lookup_addr_b);
        lookahead_a = read_entry(lookahead_addr_a);
        lookahead_b = read_entry(lookahead_addr_b);
    end

    // Issue stage must filter out r0 destinations
    a_no_mark_r0: assert property (
        @(posedge clock) disable iff (!reset)
        mark_en |-> (mark_addr != '0)
    ) else $error("scoreboard: mark request for r0");

    // A zero latency would leave no pending window
    a_mark_row_nonzero: assert property (
        @(posedge clock) disable iff (!reset)
        mark_en |-> (mark_row != '0)
    ) else $error("scoreboard: mark request with zero row");

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module register_file (
    input  logic               clock,
    input  logic               reset,
    input  isa_pkg::reg_addr_t read_addr_a,
    input  isa_pkg::reg_addr_t read_addr_b,
    input  logic               write_en,
    input  isa_pkg::reg_addr_t write_addr,
    input  isa_pkg::word_t     write_data,
    output isa_pkg::word_t     read_data_a,
    output isa_pkg::word_t     read_data_b
);

    import isa_pkg::*;

    word_t regs [`REG_COUNT];

    // Register zero is never written, so it keeps its reset value
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // Combinational read ports
    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];

    // A writeback aimed at r0 leaves it reading zero on the next cycle
    a_r0_stays_zero: assert property (
        @(posedge clock) disable iff (!reset)
        (write_en && write_addr == '0) |=> (regs[0] == '0)
    ) else $error("register_file: r0 changed after write");

endmodule

// File: design/scoreboard_pkg.sv
`include "issue_config.svh"

package scoreboard_pkg;

    // Cycles left until the pending result lands in the register file
    typedef logic [`ROW_W-1:0] row_t;

    // Answer to one scoreboard lookup
    typedef struct packed {
        logic          pending;
        isa_pkg::unit_e unit;
        row_t          row;
    } sb_lookup_t;

endpackage

// File: design/isa_pkg.sv
`include "issue_config.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]             opcode_t;
    typedef logic [5:0]             funct_t;

    typedef enum logic [1:0] {
        unit_alu  = 2'b00,
        unit_mem  = 2'b01,
        unit_mul  = 2'b10,
        unit_none = 2'b11
    } unit_e;

    // One decoded instruction as handed over by decode
    typedef struct packed {
        logic [2:0] aluop;
        logic       selalushift;
        logic       selimregb;
        logic       unsig;
        logic [1:0] shiftop;
        logic       readmem;
        logic       writemem;
        word_t      imedext;
        logic       selwsource;
        reg_addr_t  regdest;
        logic       writereg;
        logic       writeov;
        reg_addr_t  addr_a;
        reg_addr_t  addr_b;
        logic       uses_b;
        opcode_t    op;
        funct_t     funct;
    } decoded_t;

    // Controls and operands registered toward execution
    typedef struct packed {
        logic [2:0] aluop;
        logic       selalushift;
        logic       selimregb;
        logic       unsig;
        logic [1:0] shiftop;
        logic [4:0] shiftamt;
        logic       readmem;
        logic       writemem;
        word_t      imedext;
        logic       selwsource;
        reg_addr_t  regdest;
        logic       writereg;
        logic       writeov;
        word_t      rega;
        word_t      regb;
        unit_e      unit;
    } exec_t;

endpackage

// File: include/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Datapath and register file sizes
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// Unit latencies in cycles, each must fit in a countdown row
`define LAT_ALU     1
`define LAT_MEM     3
`define LAT_MUL     5
`define ROW_W       3

// Opcode and funct encodings used for unit selection
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_SPECIAL  6'b000000
`define FUNCT_MULT  6'b011000

`endif
